/* hw/laser_mem_pkg.sv */
////////////////////
// Laser 500 memory path definitions
// Address map, widths and the request structs
////////////////////
`default_nettype none

package laser_mem_pkg;

	////////////////////
	// Widths
	////////////////////

	// 256 KiB byte RAM
	localparam int RAM_AW = 18;
	localparam int DATA_W = 8;
	// Host download address bus
	localparam int DL_AW  = 25;

	////////////////////
	// Address map
	////////////////////

	// BASIC program load offset
	localparam logic [RAM_AW-1:0] PRG_OFFSET  = 18'h08995;
	// User RAM pages 3 to 7, end bound is exclusive
	localparam logic [RAM_AW-1:0] ERASE_START = 18'h0C000;
	localparam logic [RAM_AW-1:0] ERASE_END   = 18'h20000;

	// Download image indices
	localparam logic [7:0] IDX_ROM = 8'd0;
	localparam logic [7:0] IDX_PRG = 8'd1;

	////////////////////
	// Types
	////////////////////

	// Host download stream, one beat per cycle with wr high
	typedef struct packed {
		logic              active;
		logic              wr;
		logic [7:0]        index;
		logic [DL_AW-1:0]  addr;
		logic [DATA_W-1:0] data;
	} dl_req_t;

	// One RAM access
	typedef struct packed {
		logic              rd;
		logic              wr;
		logic [RAM_AW-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	// Current RAM owner
	typedef enum logic [1:0] {
		OWN_CLIENT = 2'd0,
		OWN_LOADER = 2'd1,
		OWN_ERASER = 2'd2
	} owner_t;

endpackage

`default_nettype wire

/* hw/ram_dp.sv */
////////////////////
// Byte RAM, 256 KiB
// Registered read port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ram_dp import laser_mem_pkg::*; (
	input  wire               F14M,
	input  mem_req_t          req,
	output logic [DATA_W-1:0] rdata
);

	// Block RAM array
	logic [DATA_W-1:0] mem [2**RAM_AW];

	always_ff @(posedge F14M) begin
		if (req.wr) begin
			mem[req.addr] <= req.wdata;
		end
		// Read data lands one edge after the request
		if (req.rd) begin
			rdata <= mem[req.addr];
		end
	end

endmodule

`default_nettype wire

/* hw/prg_loader.sv */
////////////////////
// Download loader
// Maps download bytes to RAM writes, staged one cycle
////////////////////
`timescale 1ns/1ps
`default_nettype none

module prg_loader import laser_mem_pkg::*; (
	input  wire      F14M,
	input  wire      arst_n,
	input  dl_req_t  dl,
	output mem_req_t load_req,
	output logic     load_pend
);

	logic              is_rom;
	logic              is_prg;
	logic              beat;
	// PRG address with the BASIC offset, full download width
	logic [DL_AW-1:0]  prg_addr;
	// Staged write payload
	logic [RAM_AW-1:0] addr_q;
	logic [DATA_W-1:0] data_q;

	assign is_rom   = (dl.index == IDX_ROM);
	assign is_prg   = (dl.index == IDX_PRG);
	// Other indices are dropped here
	assign beat     = dl.active & dl.wr & (is_rom | is_prg);
	assign prg_addr = dl.addr + DL_AW'(PRG_OFFSET);

	// Pending flag marks the staged cycle
	always_ff @(posedge F14M or negedge arst_n) begin
		if (!arst_n) begin
			load_pend <= 1'b0;
		end else begin
			load_pend <= beat;
		end
	end

	// Payload, truncated to the RAM address width
	always_ff @(posedge F14M) begin
		if (beat) begin
			addr_q <= is_prg ? prg_addr[RAM_AW-1:0] : dl.addr[RAM_AW-1:0];
			data_q <= dl.data;
		end
	end

	always_comb begin
		load_req       = '0;
		load_req.wr    = load_pend;
		load_req.addr  = addr_q;
		load_req.wdata = data_q;
	end

endmodule

`default_nettype wire

/* hw/ram_eraser.sv */
////////////////////
// RAM eraser
// Zero-fills the user RAM pages after a soft reset
////////////////////
`timescale 1ns/1ps
`default_nettype none

module ram_eraser import laser_mem_pkg::*; (
	input  wire      F14M,
	input  wire      arst_n,
	input  wire      start,
	input  wire      grant,
	output mem_req_t erase_req,
	output logic     erasing
);

	// Address walker
	logic [RAM_AW-1:0] addr_q;
	// Last address of the region
	logic              at_last;

	assign at_last = (addr_q == ERASE_END - 1'b1);

	always_ff @(posedge F14M or negedge arst_n) begin
		if (!arst_n) begin
			addr_q  <= ERASE_START;
			erasing <= 1'b0;
		end else if (start) begin
			// A new start restarts the walk from the bottom
			addr_q  <= ERASE_START;
			erasing <= 1'b1;
		end else if (erasing && grant) begin
			addr_q <= addr_q + 1'b1;
			// Done once the top byte is written
			if (at_last) begin
				erasing <= 1'b0;
			end
		end
	end

	// Zero write on every granted cycle, address held otherwise
	always_comb begin
		erase_req       = '0;
		erase_req.wr    = erasing & grant;
		erase_req.addr  = addr_q;
		erase_req.wdata = '0;
	end

endmodule

`default_nettype wire

/* hw/mem_ctrl.sv */
////////////////////
// Memory control
// Picks the RAM owner each cycle, drives hold and blank
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl import laser_mem_pkg::*; (
	input  wire    F14M,
	input  wire    arst_n,
	input  wire    soft_reset,
	input  wire    dl_active,
	input  wire    load_pend,
	input  wire    erasing,
	output owner_t owner,
	output logic   erase_start,
	output logic   erase_grant,
	output logic   cpu_hold,
	output logic   blank
);

	// Previous soft_reset level
	logic soft_reset_q;

	always_ff @(posedge F14M or negedge arst_n) begin
		if (!arst_n) begin
			soft_reset_q <= 1'b0;
		end else begin
			soft_reset_q <= soft_reset;
		end
	end

	// One-cycle pulse on the rising edge of soft_reset
	assign erase_start = soft_reset & ~soft_reset_q;

	////////////////////
	// Owner selection
	////////////////////

	// Eraser only runs when the loader has no staged write
	assign erase_grant = erasing & ~load_pend;

	// Fixed priority, download first, then eraser, then client
	always_comb begin
		if (load_pend) begin
			owner = OWN_LOADER;
		end else if (erasing) begin
			owner = OWN_ERASER;
		end else begin
			owner = OWN_CLIENT;
		end
	end

	////////////////////
	// Hold and blank
	////////////////////

	always_ff @(posedge F14M or negedge arst_n) begin
		if (!arst_n) begin
			cpu_hold <= 1'b0;
			blank    <= 1'b0;
		end else begin
			// CPU also held while soft reset is pressed
			cpu_hold <= dl_active | erasing | soft_reset;
			blank    <= dl_active | erasing;
		end
	end

endmodule

`default_nettype wire

/* hw/mem_port_mux.sv */
////////////////////
// RAM port mux
// Steers the owner's request, returns client read data
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_port_mux import laser_mem_pkg::*; (
	input  wire               F14M,
	input  wire               arst_n,
	input  owner_t            owner,
	input  mem_req_t          load_req,
	input  mem_req_t          erase_req,
	input  mem_req_t          client_req,
	input  wire               hold,
	output mem_req_t          ram_req,
	input  wire  [DATA_W-1:0] ram_rdata,
	output logic [DATA_W-1:0] client_rdata
);

	// Client access after the hold mask
	mem_req_t client_ok;
	// Read issued last cycle, RAM data is ready now
	logic     rd_q;

	// Held client accesses are dropped, not queued
	assign client_ok = hold ? '0 : client_req;

	////////////////////
	// Request path
	////////////////////

	always_comb begin
		case (owner)
			OWN_LOADER: ram_req = load_req;
			OWN_ERASER: ram_req = erase_req;
			default:    ram_req = client_ok;
		endcase
	end

	////////////////////
	// Read return
	////////////////////

	// One flag per cycle, so back-to-back reads overlap
	always_ff @(posedge F14M or negedge arst_n) begin
		if (!arst_n) begin
			rd_q         <= 1'b0;
			client_rdata <= '0;
		end else begin
			rd_q <= (owner == OWN_CLIENT) & client_ok.rd;
			// Keep the last read value between reads
			if (rd_q) begin
				client_rdata <= ram_rdata;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/laser_mem_top.sv */
////////////////////
// Laser 500 memory path
// Download, eraser and client sharing one byte RAM
////////////////////
`timescale 1ns/1ps
`default_nettype none

module laser_mem_top import laser_mem_pkg::*; (
	input  wire               F14M,
	input  wire               arst_n,
	input  wire               soft_reset,
	input  dl_req_t           dl,
	input  mem_req_t          client_req,
	output logic [DATA_W-1:0] client_rdata,
	output logic              cpu_hold,
	output logic              blank
);

	// Control
	owner_t            owner;
	logic              erase_start;
	logic              erase_grant;
	logic              erasing;
	logic              load_pend;
	// Requests
	mem_req_t          load_req;
	mem_req_t          erase_req;
	mem_req_t          ram_req;
	logic [DATA_W-1:0] ram_rdata;

	////////////////////
	// Control
	////////////////////

	mem_ctrl ctrl_i (
		.F14M        (F14M),
		.arst_n      (arst_n),
		.soft_reset  (soft_reset),
		.dl_active   (dl.active),
		.load_pend   (load_pend),
		.erasing     (erasing),
		.owner       (owner),
		.erase_start (erase_start),
		.erase_grant (erase_grant),
		.cpu_hold    (cpu_hold),
		.blank       (blank)
	);

	////////////////////
	// Requesters
	////////////////////

	prg_loader loader_i (
		.F14M      (F14M),
		.arst_n    (arst_n),
		.dl        (dl),
		.load_req  (load_req),
		.load_pend (load_pend)
	);

	ram_eraser eraser_i (
		.F14M      (F14M),
		.arst_n    (arst_n),
		.start     (erase_start),
		.grant     (erase_grant),
		.erase_req (erase_req),
		.erasing   (erasing)
	);

	////////////////////
	// RAM and port mux
	////////////////////

	// Client is masked by the registered CPU hold
	mem_port_mux mux_i (
		.F14M         (F14M),
		.arst_n       (arst_n),
		.owner        (owner),
		.load_req     (load_req),
		.erase_req    (erase_req),
		.client_req   (client_req),
		.hold         (cpu_hold),
		.ram_req      (ram_req),
		.ram_rdata    (ram_rdata),
		.client_rdata (client_rdata)
	);

	ram_dp ram_i (
		.F14M  (F14M),
		.req   (ram_req),
		.rdata (ram_rdata)
	);

endmodule

`default_nettype wire

/* tb/mem_checker.sv */
////////////////////
// Memory path checker
// Reference RAM image, erase walk model, read compare
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_checker import laser_mem_pkg::*; (
	input  wire               F14M,
	input  wire               arst_n,
	input  wire               soft_reset,
	input  dl_req_t           dl,
	input  mem_req_t          client_req,
	input  wire               cpu_hold,
	input  wire  [DATA_W-1:0] client_rdata
);

	// Reference image of the RAM
	logic [DATA_W-1:0] ref_mem [2**RAM_AW];
	int                err_cnt = 0;
	string             cur_test = "none";

	// Erase walk, one zero byte per cycle not taken by a download write
	logic              sr_q;
	logic              er_on;
	logic [RAM_AW-1:0] er_addr;
	logic              pend;

	// Reads in flight, stage 1 is compared
	logic              rd_v [2];
	logic [RAM_AW-1:0] rd_a [2];
	logic [DATA_W-1:0] rd_e [2];

	task automatic set_test(input string name);
		cur_test = name;
	endtask

	// Mirror of a write that the DUT accepted
	task automatic write_byte(input logic [RAM_AW-1:0] a, input logic [DATA_W-1:0] d);
		ref_mem[a] = d;
	endtask

	task automatic flag_error(input string msg);
		$display("error in %s: %s", cur_test, msg);
		err_cnt++;
	endtask

	// Last accepted byte, zero once the eraser has passed the address
	function automatic logic [DATA_W-1:0] expected_byte(input logic [RAM_AW-1:0] a);
		return ref_mem[a];
	endfunction

	always @(posedge F14M) begin
		if (!arst_n) begin
			sr_q    = 1'b0;
			er_on   = 1'b0;
			er_addr = ERASE_START;
			pend    = 1'b0;
			rd_v[0] = 1'b0;
			rd_v[1] = 1'b0;
		end else begin
			// Data came out on the edge after the request
			if (rd_v[1] && client_rdata !== rd_e[1]) begin
				$display("mismatch %s: addr %05h expected %02h actual %02h",
					cur_test, rd_a[1], rd_e[1], client_rdata);
				err_cnt++;
			end
			rd_v[1] = rd_v[0];
			rd_a[1] = rd_a[0];
			rd_e[1] = rd_e[0];
			// Held reads never reach the RAM
			rd_v[0] = client_req.rd & ~cpu_hold;
			rd_a[0] = client_req.addr;
			rd_e[0] = expected_byte(client_req.addr);

			// Eraser yields to a staged download write
			if (er_on && !pend) begin
				ref_mem[er_addr] = '0;
				if (er_addr == ERASE_END - 18'd1) begin
					er_on = 1'b0;
				end
				er_addr = er_addr + 18'd1;
			end
			if (soft_reset && !sr_q) begin
				er_on   = 1'b1;
				er_addr = ERASE_START;
			end
			sr_q = soft_reset;
			pend = dl.active & dl.wr & ((dl.index == IDX_ROM) | (dl.index == IDX_PRG));
		end
	end

endmodule

`default_nettype wire

/* tb/tb_top.sv */
////////////////////
// Memory path testbench
// Clock, reset, stimulus and watchdog around the DUT
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_top import laser_mem_pkg::*; ();

	// Two erasing tests, one region walk each plus slack
	localparam int LIMIT_CYCLES = (81920 + 200) * 2 + 20000 + 5000;

	logic              F14M;
	logic              arst_n;
	logic              soft_reset;
	dl_req_t           dl;
	mem_req_t          client_req;
	logic [DATA_W-1:0] client_rdata;
	logic              cpu_hold;
	logic              blank;

	logic [31:0]       rng;
	// Every address that the final reads of a test cover
	logic [RAM_AW-1:0] used_q [$];
	string             phase;
	int                n_pass;
	int                n_fail;
	int                err_base;

	laser_mem_top dut_i (.*);

	mem_checker chk_i (.*);

	initial F14M = 1'b0;
	always #50 F14M = ~F14M;

	// LCG step, rotated so the low bits vary too
	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return {rng[15:0], rng[31:16]};
	endfunction

	function automatic logic [RAM_AW-1:0] rand_addr(input logic [31:0] base,
			input logic [31:0] span);
		logic [31:0] v;
		v = base + next_rand() % span;
		return v[RAM_AW-1:0];
	endfunction

	// Inputs change just after the rising edge
	task automatic tick();
		@(posedge F14M);
		#10;
	endtask

	task automatic client_write(input logic [RAM_AW-1:0] a, input logic [DATA_W-1:0] d);
		client_req = '{rd: 1'b0, wr: 1'b1, addr: a, wdata: d};
		if (!cpu_hold) begin
			chk_i.write_byte(a, d);
		end
		tick();
		client_req = '0;
	endtask

	task automatic client_read(input logic [RAM_AW-1:0] a);
		client_req = '{rd: 1'b1, wr: 1'b0, addr: a, wdata: '0};
		tick();
		client_req = '0;
	endtask

	// Back-to-back reads, then let the last ones drain
	task automatic read_used();
		foreach (used_q[i]) begin
			client_read(used_q[i]);
		end
		repeat (3) tick();
	endtask

	// One download beat, ROM at its address, PRG at the BASIC offset
	task automatic dl_write(input logic [7:0] idx, input logic [DL_AW-1:0] a,
			input logic [DATA_W-1:0] d);
		logic [RAM_AW-1:0] t;
		t = a[RAM_AW-1:0];
		// BASIC load offset, wrapping inside the 256 KiB RAM
		if (idx == IDX_PRG) begin
			t = t + 18'h08995;
		end
		dl.wr    = 1'b1;
		dl.index = idx;
		dl.addr  = a;
		dl.data  = d;
		if (idx == IDX_ROM || idx == IDX_PRG) begin
			chk_i.write_byte(t, d);
			used_q.push_back(t);
		end
		tick();
		dl.wr = 1'b0;
	endtask

	task automatic check_level(input logic ok, input string msg);
		if (!ok) begin
			chk_i.flag_error(msg);
		end
	endtask

	task automatic start_test(input string name);
		phase    = name;
		err_base = chk_i.err_cnt;
		chk_i.set_test(name);
	endtask

	task automatic end_test(input string name);
		if (chk_i.err_cnt == err_base) begin
			n_pass++;
			$display("test %s ok", name);
		end else begin
			n_fail++;
			$display("test %s failed with %0d errors", name, chk_i.err_cnt - err_base);
		end
	endtask

	// Blank marks the whole erase
	task automatic wait_erase();
		phase = {phase, " erase wait"};
		while (blank) begin
			tick();
		end
		check_level(!chk_i.er_on, "blank fell before the erase region was cleared");
	endtask

	initial begin
		logic [31:0]       r;
		logic [RAM_AW-1:0] a;
		rng        = 32'hebb09240;
		arst_n     = 1'b0;
		soft_reset = 1'b0;
		dl         = '0;
		client_req = '0;
		n_pass     = 0;
		n_fail     = 0;
		phase      = "reset";
		repeat (3) @(posedge F14M);
		#10;
		arst_n = 1'b1;
		tick();

		////////////////////
		// Client path
		////////////////////
		start_test("client_rw");
		check_level(!cpu_hold && !blank, "cpu_hold or blank high after reset");
		repeat (16) begin
			r = next_rand();
			a = rand_addr(0, 32'(2**RAM_AW));
			client_write(a, r[31:24]);
			used_q.push_back(a);
		end
		read_used();
		end_test("client_rw");

		////////////////////
		// Downloads
		////////////////////
		start_test("rom_download");
		dl.active = 1'b1;
		tick();
		repeat (16) begin
			r = next_rand();
			dl_write(IDX_ROM, r[DL_AW-1:0], r[31:24]);
			check_level(cpu_hold && blank, "cpu_hold or blank low during download");
		end
		dl = '0;
		repeat (3) tick();
		read_used();
		end_test("rom_download");

		start_test("prg_download");
		dl.active = 1'b1;
		tick();
		// Sources are known bytes, so their old value is checked too
		repeat (8) begin
			r = next_rand();
			dl_write(IDX_PRG, {r[6:0], used_q[r % used_q.size()]}, r[31:24]);
		end
		// Index 2 is no known image
		repeat (4) begin
			r = next_rand();
			dl_write(8'd2, {7'd0, used_q[r % used_q.size()]}, r[23:16]);
		end
		dl = '0;
		repeat (3) tick();
		read_used();
		end_test("prg_download");

		////////////////////
		// Soft reset erase
		////////////////////
		start_test("soft_reset_erase");
		repeat (8) begin
			r = next_rand();
			a = rand_addr(0, 32'(ERASE_START));
			client_write(a, r[31:24]);
			used_q.push_back(a);
			a = rand_addr(32'(ERASE_START), 32'h14000);
			client_write(a, r[23:16]);
			used_q.push_back(a);
		end
		soft_reset = 1'b1;
		tick();
		check_level(cpu_hold, "cpu_hold not raised by soft_reset");
		repeat (2) tick();
		soft_reset = 1'b0;
		wait_erase();
		repeat (16) used_q.push_back(rand_addr(32'(ERASE_START), 32'h14000));
		read_used();
		end_test("soft_reset_erase");

		start_test("hold_and_preempt");
		// Idle download cycles leave the client as RAM owner
		// Only the hold mask keeps these writes out
		dl.active = 1'b1;
		tick();
		foreach (used_q[i]) begin
			if (used_q[i] < ERASE_START) begin
				check_level(cpu_hold, "cpu_hold low during download");
				client_write(used_q[i], 8'ha5);
			end
		end
		dl = '0;
		tick();
		soft_reset = 1'b1;
		tick();
		soft_reset = 1'b0;
		// Held client writes must never reach the RAM
		for (int i = 0; i < 8; i++) begin
			check_level(cpu_hold, "cpu_hold low during erase");
			client_write(used_q[i], 8'h5a);
		end
		dl.active = 1'b1;
		// Top of the region is cleared later, low RAM is outside it
		repeat (8) begin
			r = next_rand();
			dl_write(IDX_ROM, {7'd0, rand_addr(32'h1F000, 32'h1000)}, r[31:24]);
			dl_write(IDX_ROM, {7'd0, rand_addr(0, 32'(ERASE_START))}, r[23:16]);
		end
		// Eraser is well past the first KiB of its region by now
		repeat (3000) tick();
		repeat (8) begin
			r = next_rand();
			dl_write(IDX_ROM, {7'd0, rand_addr(32'(ERASE_START), 32'h400)}, r[31:24]);
		end
		dl = '0;
		wait_erase();
		read_used();
		end_test("hold_and_preempt");

		$display("%0d tests ok, %0d tests failed, %0d errors", n_pass, n_fail, chk_i.err_cnt);
		if (n_fail == 0 && chk_i.err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Bound from the erase length of the two erasing tests
	initial begin
		repeat (LIMIT_CYCLES) @(posedge F14M);
		$display("Watchdog expired, the %s phase never finished", phase);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hw/laser_mem_pkg.sv
hw/ram_dp.sv
hw/prg_loader.sv
hw/ram_eraser.sv
hw/mem_ctrl.sv
hw/mem_port_mux.sv
hw/laser_mem_top.sv
tb/mem_checker.sv
tb/tb_top.sv

/* Makefile */
TOP = tb_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f build.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
